// File: tb.f
+incdir+source
source/dmem_pkg.sv
source/dcache_tags.sv
source/store_buffer.sv
source/tl_control.sv
source/tl_stage.sv
sim/tl_stage_tb.sv

// File: sim/tl_stage_tb.sv
`default_nettype none

module tl_stage_tb;

    localparam int TIMEOUT = 40;

    typedef struct packed {
        dmem_pkg::addr_t       addr;
        dmem_pkg::word_t       data;
        dmem_pkg::memop_type_e mtype;
    } model_entry_t;

    logic                clk;
    logic                rst_n;
    dmem_pkg::ex_req_t   req;
    dmem_pkg::mmu_fill_t fill;
    logic                store_permission;
    dmem_pkg::mem_out_t  mem_out;
    logic                mmu_miss;
    dmem_pkg::addr_t     mmu_addr;
    logic                mmu_access;
    logic                hazard;

    // Reference store buffer with the oldest entry at the front
    model_entry_t        model_q[$];
    logic [31:0]         lcg_state;
    dmem_pkg::addr_t     line_base;
    dmem_pkg::instr_id_t next_id;
    string               test_name;
    int                  errors;
    int                  errors_at_start;
    int                  tests_run;
    int                  tests_passed;
    int                  flush_count;

    tl_stage UUT (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .req_i              (req),
        .fill_i             (fill),
        .store_permission_i (store_permission),
        .mem_o              (mem_out),
        .mmu_miss_o         (mmu_miss),
        .mmu_addr_o         (mmu_addr),
        .mmu_cache_access_o (mmu_access),
        .pipeline_hazard_o  (hazard)
    );

    always #2 clk = ~clk;

    stall_blocks_issue: assert property (@(posedge clk) disable iff (!rst_n)
        hazard |=> (!mem_out.rd && !mem_out.rf_we && !mem_out.sb_merge))
    else begin
        $display("%s: a stalled request still reached the memory stage", test_name);
        errors++;
    end

    flush_is_write: assert property (@(posedge clk) disable iff (!rst_n)
        mem_out.sb_flush |-> (mem_out.wr && !mem_out.rd))
    else begin
        $display("%s: a flush went out without a write strobe", test_name);
        errors++;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int model_find(input dmem_pkg::addr_t addr,
                                      input dmem_pkg::memop_type_e mtype);
        int idx;
        idx = -1;
        foreach (model_q[i]) begin
            if ((model_q[i].addr == addr) && (model_q[i].mtype == mtype)) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Entries sharing the data word of addr
    function automatic int model_word_hits(input dmem_pkg::addr_t addr);
        int hits;
        hits = 0;
        foreach (model_q[i]) begin
            if (model_q[i].addr[31:2] == addr[31:2]) begin
                hits++;
            end
        end
        return hits;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // Advance one clock and match any flush on the stage output against the model head
    task automatic step();
        model_entry_t head;
        @(posedge clk);
        #1;
        if (mem_out.sb_flush) begin
            flush_count++;
            if (model_q.size() == 0) begin
                check_true(1'b0, "a flush came out of an empty store buffer");
            end else begin
                head = model_q.pop_front();
                check_value("flush address", head.addr, mem_out.sb_addr);
                check_value("flush data", head.data, mem_out.sb_data_flush);
                check_value("flush type", head.mtype, mem_out.flush_mtype);
            end
        end
    endtask

    // Holds one access until the stage takes it, then checks the stage output
    task automatic issue(input logic is_store, input dmem_pkg::addr_t addr,
                         input dmem_pkg::memop_type_e mtype, input dmem_pkg::word_t data,
                         input int allow_after, output int stall_cycles);
        int              idx;
        logic            exp_merge;
        logic            exp_hit;
        dmem_pkg::word_t exp_data;
        model_entry_t    entry;
        req          = '0;
        req.addr     = addr;
        req.rd       = !is_store;
        req.wr       = is_store;
        req.rf_we    = !is_store;
        req.rf_waddr = 5'd10;
        req.st_data  = data;
        req.mtype    = mtype;
        req.instr_id = next_id;
        next_id      = next_id + 1'b1;
        stall_cycles = 0;
        @(negedge clk);
        while (hazard) begin
            if (stall_cycles >= TIMEOUT) begin
                abort_on_timeout("the stall to clear");
            end
            step();
            stall_cycles++;
            if (stall_cycles == allow_after) begin
                store_permission = 1'b1;
            end
            @(negedge clk);
        end
        check_value("cache access", 1, mmu_access);
        idx       = model_find(addr, mtype);
        exp_merge = is_store && (idx >= 0);
        exp_hit   = is_store ? exp_merge : ((idx >= 0) && (model_word_hits(addr) == 1));
        exp_data  = (idx >= 0) ? model_q[idx].data : '0;
        entry     = '{addr: addr, data: data, mtype: mtype};
        if (is_store && (idx >= 0)) begin
            model_q[idx] = entry;
        end else if (is_store) begin
            model_q.push_back(entry);
        end
        step();
        req = '0;
        check_value("read strobe", !is_store, mem_out.rd);
        check_value("write strobe", 0, mem_out.wr);
        check_value("merge flag", exp_merge, mem_out.sb_merge);
        check_value("buffer hit", exp_hit, mem_out.sb_hit);
        if (!is_store && exp_hit) begin
            check_value("forwarded data", exp_data, mem_out.sb_data_load);
        end
    endtask

    task automatic drain_buffer();
        int cycles;
        cycles           = 0;
        store_permission = 1'b1;
        while (model_q.size() != 0) begin
            if (cycles >= TIMEOUT) begin
                abort_on_timeout("the store buffer to drain");
            end
            step();
            cycles++;
        end
        // An emptied buffer must not flush again
        step();
        store_permission = 1'b0;
    endtask

    task automatic reset_outputs();
        start_test("reset");
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("stall", 0, hazard);
        check_value("miss request", 0, mmu_miss);
        check_value("cache access", 0, mmu_access);
        check_value("read strobe", 0, mem_out.rd);
        check_value("write strobe", 0, mem_out.wr);
        check_value("flush flag", 0, mem_out.sb_flush);
        step();
        end_test();
    endtask

    task automatic load_miss_fill();
        int              stall;
        logic [31:0]     rnd;
        dmem_pkg::addr_t load_addr;
        start_test("load_miss");
        rnd          = lcg_next();
        line_base    = {rnd[31:4], 4'h0};
        load_addr    = line_base + 32'h4;
        req          = '0;
        req.addr     = load_addr;
        req.rd       = 1'b1;
        req.rf_we    = 1'b1;
        req.mtype    = dmem_pkg::WORD;
        req.instr_id = next_id;
        @(negedge clk);
        check_value("stall", 1, hazard);
        check_value("miss request", 1, mmu_miss);
        check_value("miss address", load_addr, mmu_addr);
        repeat (3) begin
            step();
            @(negedge clk);
            check_value("stall before fill", 1, hazard);
        end
        step();
        fill.rdy       = 1'b1;
        fill.lru_index = 2'd2;
        fill.addr      = line_base;
        step();
        fill = '0;
        issue(1'b0, load_addr, dmem_pkg::WORD, '0, -1, stall);
        check_value("stall after fill", 0, stall);
        check_value("line index", 2, mem_out.addr_index);
        check_value("load address", load_addr, mem_out.addr);
        end_test();
    endtask

    task automatic store_forwarding();
        int              stall;
        dmem_pkg::word_t first_data;
        dmem_pkg::word_t second_data;
        start_test("store_forwarding");
        first_data  = lcg_next();
        second_data = lcg_next();
        issue(1'b1, line_base + 32'h4, dmem_pkg::WORD, first_data, -1, stall);
        check_value("store stall", 0, stall);
        issue(1'b0, line_base + 32'h4, dmem_pkg::WORD, '0, -1, stall);
        check_value("load data", first_data, mem_out.sb_data_load);
        issue(1'b1, line_base + 32'h4, dmem_pkg::WORD, second_data, -1, stall);
        check_value("merge flag", 1, mem_out.sb_merge);
        end_test();
    endtask

    task automatic flush_order();
        int stall;
        int flushes_before;
        start_test("flush_order");
        issue(1'b1, line_base + 32'h9, dmem_pkg::BYTE, lcg_next(), -1, stall);
        flushes_before = flush_count;
        drain_buffer();
        check_value("flushes", 2, flush_count - flushes_before);
        end_test();
    endtask

    task automatic full_buffer_stall();
        int stall;
        start_test("full_buffer");
        issue(1'b1, line_base, dmem_pkg::WORD, lcg_next(), -1, stall);
        issue(1'b1, line_base + 32'h4, dmem_pkg::WORD, lcg_next(), -1, stall);
        issue(1'b1, line_base + 32'hc, dmem_pkg::WORD, lcg_next(), 6, stall);
        check_true(stall > 6, "the full buffer did not hold the stall until a flush");
        check_value("buffered entries", 2, model_q.size());
        drain_buffer();
        end_test();
    endtask

    task automatic overlap_load_stall();
        int stall;
        start_test("overlap_load");
        issue(1'b1, line_base + 32'h8, dmem_pkg::WORD, lcg_next(), -1, stall);
        // Byte load inside the buffered word cannot be forwarded
        issue(1'b0, line_base + 32'h9, dmem_pkg::BYTE, '0, 5, stall);
        check_true(stall > 5, "the overlapping load was not held until the flush");
        check_value("buffered entries", 0, model_q.size());
        store_permission = 1'b0;
        end_test();
    endtask

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        req              = '0;
        fill             = '0;
        store_permission = 1'b0;
        lcg_state        = 32'd126;
        next_id          = '0;
        errors           = 0;
        tests_run        = 0;
        tests_passed     = 0;
        flush_count      = 0;
        test_name        = "setup";
        reset_outputs();
        load_miss_fill();
        store_forwarding();
        flush_order();
        full_buffer_stall();
        overlap_load_stall();
        $display("%0d of %0d tests passed, %0d checks failed", tests_passed, tests_run, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/tl_stage.sv
`default_nettype none

module tl_stage (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire dmem_pkg::ex_req_t    req_i,
    input  wire dmem_pkg::mmu_fill_t  fill_i,
    input  wire logic                 store_permission_i,
    output dmem_pkg::mem_out_t        mem_o,
    output logic                      mmu_miss_o,
    output dmem_pkg::addr_t           mmu_addr_o,
    output logic                      mmu_cache_access_o,
    output logic                      pipeline_hazard_o
);

    dmem_pkg::tag_lookup_t lookup;
    dmem_pkg::sb_status_t  sb;
    dmem_pkg::tl_state_e   state;
    dmem_pkg::mem_out_t    mem_d;
    dmem_pkg::mem_out_t    mem_q;

    logic lookup_en;
    logic store_en;
    logic load_en;
    logic flush_en;
    logic hazard;

    dcache_tags u_tags (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lookup_en_i (lookup_en),
        .addr_i      (req_i.addr),
        .fill_i      (fill_i),
        .lookup_o    (lookup)
    );

    store_buffer u_sb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .store_en_i (store_en),
        .load_en_i  (load_en),
        .flush_en_i (flush_en),
        .addr_i     (req_i.addr),
        .data_i     (req_i.st_data),
        .mtype_i    (req_i.mtype),
        .id_i       (req_i.instr_id),
        .status_o   (sb)
    );

    tl_control u_ctrl (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .req_i              (req_i),
        .fill_rdy_i         (fill_i.rdy),
        .store_permission_i (store_permission_i),
        .lookup_i           (lookup),
        .sb_i               (sb),
        .lookup_en_o        (lookup_en),
        .store_en_o         (store_en),
        .load_en_o          (load_en),
        .flush_en_o         (flush_en),
        .hazard_o           (hazard),
        .mmu_miss_o         (mmu_miss_o),
        .state_o            (state)
    );

    // Victim line goes out during a fill for write-back
    assign mmu_addr_o         = fill_i.rdy ? lookup.victim_addr : req_i.addr;
    assign mmu_cache_access_o = lookup_en | store_en | load_en;
    assign pipeline_hazard_o  = hazard;

    always_comb begin
        mem_d = mem_q;
        if (!hazard) begin
            mem_d.addr          = req_i.addr;
            mem_d.rf_we         = req_i.rf_we;
            mem_d.rf_waddr      = req_i.rf_waddr;
            mem_d.sign_ext      = req_i.sign_ext;
            mem_d.mtype         = req_i.mtype;
            mem_d.addr_index    = lookup.index;
            mem_d.flush_mtype   = sb.head_mtype;
            mem_d.sb_addr       = sb.head_addr;
            mem_d.sb_data_flush = sb.head_data;
            mem_d.sb_data_load  = sb.data_load;
            mem_d.sb_merge      = sb.merge;
            mem_d.instr_id      = req_i.instr_id;
            mem_d.sb_flush      = flush_en;
            if (flush_en) begin
                // Buffer head drains towards the cache
                mem_d.rd       = 1'b0;
                mem_d.wr       = 1'b1;
                mem_d.sb_hit   = 1'b0;
                mem_d.instr_id = sb.head_id;
            end else begin
                // Stores only reach the cache through the buffer
                mem_d.rd     = req_i.rd;
                mem_d.wr     = 1'b0;
                mem_d.sb_hit = sb.hit;
            end
        end else begin
            mem_d.rd       = 1'b0;
            mem_d.rf_we    = 1'b0;
            mem_d.sb_merge = 1'b0;
            mem_d.sb_hit   = 1'b0;
            mem_d.wr       = 1'b0;
            mem_d.sb_flush = 1'b0;
            // Draining goes on while stalled on buffer trouble
            if ((state == dmem_pkg::HAZARD_SB_TROUBLE) && flush_en) begin
                mem_d.wr            = 1'b1;
                mem_d.sb_flush      = 1'b1;
                mem_d.sb_addr       = sb.head_addr;
                mem_d.sb_data_flush = sb.head_data;
                mem_d.flush_mtype   = sb.head_mtype;
                mem_d.instr_id      = sb.head_id;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_q.rd       <= 1'b0;
            mem_q.wr       <= 1'b0;
            mem_q.rf_we    <= 1'b0;
            mem_q.sb_flush <= 1'b0;
            mem_q.sb_hit   <= 1'b0;
            mem_q.sb_merge <= 1'b0;
        end else begin
            mem_q <= mem_d;
        end
    end

    assign mem_o = mem_q;

endmodule

`default_nettype wire

// File: source/tl_control.sv
`include "dmem_cfg.svh"

`default_nettype none

module tl_control (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire dmem_pkg::ex_req_t      req_i,
    input  wire logic                   fill_rdy_i,
    input  wire logic                   store_permission_i,
    input  wire dmem_pkg::tag_lookup_t  lookup_i,
    input  wire dmem_pkg::sb_status_t   sb_i,
    output logic                        lookup_en_o,
    output logic                        store_en_o,
    output logic                        load_en_o,
    output logic                        flush_en_o,
    output logic                        hazard_o,
    output logic                        mmu_miss_o,
    output dmem_pkg::tl_state_e         state_o
);

    dmem_pkg::tl_state_e state_q;
    dmem_pkg::tl_state_e state_d;
    dmem_pkg::line_tag_t req_tag;
    dmem_pkg::line_tag_t flight_tag_q;

    logic in_idle;
    logic in_flight;
    logic access;
    logic same_line;
    logic capture_tag;
    logic st_stall;
    logic ld_stall;

    assign req_tag   = req_i.addr[`DMEM_ADDR_W-1:`DMEM_OFFSET_W];
    assign in_idle   = (state_q == dmem_pkg::TL_IDLE);
    assign in_flight = (state_q == dmem_pkg::MISS_IN_FLIGHT);
    assign access    = req_i.rd | req_i.wr;
    assign same_line = (req_tag == flight_tag_q);

    assign lookup_en_o = (in_idle | in_flight) & access;
    assign load_en_o   = (in_idle | in_flight) & req_i.rd;
    // With a line in flight only stores to that same line enter the buffer
    assign store_en_o  = req_i.wr & (in_idle | (in_flight & same_line));

    assign flush_en_o = store_permission_i & sb_i.data_valid &
                        ((in_idle & ~access) | (state_q == dmem_pkg::HAZARD_SB_TROUBLE));

    assign mmu_miss_o = lookup_en_o & lookup_i.miss & sb_i.miss;

    // Hazards while the store miss is outstanding
    assign st_stall = req_i.wr & (~same_line | sb_i.trouble);
    assign ld_stall = req_i.rd & lookup_i.miss & (~same_line | sb_i.miss | sb_i.trouble);

    assign capture_tag = in_idle & req_i.wr & lookup_i.miss;

    always_comb begin
        hazard_o = 1'b0;
        state_d  = state_q;
        unique case (state_q)
            dmem_pkg::TL_IDLE: begin
                hazard_o = sb_i.trouble | (req_i.rd & lookup_i.miss & sb_i.miss);
                if (req_i.wr & lookup_i.miss) begin
                    // A merged store requests no line, so nothing is left in flight
                    if (sb_i.trouble) begin
                        state_d = dmem_pkg::HAZARD_SB_TROUBLE;
                    end else if (sb_i.miss) begin
                        state_d = dmem_pkg::MISS_IN_FLIGHT;
                    end
                end else if (req_i.rd & lookup_i.miss & sb_i.miss) begin
                    state_d = dmem_pkg::HAZARD_DC_MISS;
                end else if (sb_i.trouble) begin
                    state_d = dmem_pkg::HAZARD_SB_TROUBLE;
                end
            end
            dmem_pkg::MISS_IN_FLIGHT: begin
                hazard_o = st_stall | ld_stall;
                if (fill_rdy_i) begin
                    state_d = dmem_pkg::TL_IDLE;
                end else if (st_stall | ld_stall) begin
                    state_d = dmem_pkg::HAZARD_DC_MISS;
                end
            end
            dmem_pkg::HAZARD_DC_MISS: begin
                hazard_o = 1'b1;
                if (fill_rdy_i) begin
                    state_d = dmem_pkg::TL_IDLE;
                end
            end
            dmem_pkg::HAZARD_SB_TROUBLE: begin
                hazard_o = 1'b1;
                if (!sb_i.trouble) begin
                    state_d = dmem_pkg::TL_IDLE;
                end
            end
            default: begin
                state_d = dmem_pkg::TL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= dmem_pkg::TL_IDLE;
            flight_tag_q <= '0;
        end else begin
            state_q <= state_d;
            if (capture_tag) begin
                flight_tag_q <= req_tag;
            end
        end
    end

    assign state_o = state_q;

endmodule

`default_nettype wire

// File: source/store_buffer.sv
`include "dmem_cfg.svh"

`default_nettype none

module store_buffer (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   store_en_i,
    input  wire logic                   load_en_i,
    input  wire logic                   flush_en_i,
    input  wire dmem_pkg::addr_t        addr_i,
    input  wire dmem_pkg::word_t        data_i,
    input  wire dmem_pkg::memop_type_e  mtype_i,
    input  wire dmem_pkg::instr_id_t    id_i,
    output dmem_pkg::sb_status_t        status_o
);

    localparam int DEPTH  = `DMEM_SB_ENTRIES;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // Byte offset bits inside a data word
    localparam int BYTE_W = $clog2(`DMEM_DATA_W / 8);

    typedef struct packed {
        dmem_pkg::addr_t       addr;
        dmem_pkg::word_t       data;
        dmem_pkg::memop_type_e mtype;
        dmem_pkg::instr_id_t   id;
    } entry_t;

    entry_t           entry_q [DEPTH];
    logic [DEPTH-1:0] valid_q;
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;

    logic [DEPTH-1:0] exact_match;
    logic [DEPTH-1:0] word_match;
    logic [PTR_W-1:0] match_idx;
    logic             full;
    logic             empty;
    logic             do_merge;
    logic             do_append;
    logic             do_pop;
    logic             load_hit;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        exact_match = '0;
        word_match  = '0;
        match_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] &&
                (entry_q[i].addr[`DMEM_ADDR_W-1:BYTE_W] == addr_i[`DMEM_ADDR_W-1:BYTE_W])) begin
                word_match[i] = 1'b1;
                if ((entry_q[i].addr == addr_i) && (entry_q[i].mtype == mtype_i)) begin
                    exact_match[i] = 1'b1;
                    match_idx      = PTR_W'(i);
                end
            end
        end
    end

    assign full  = &valid_q;
    assign empty = ~(|valid_q);

    // Merging keeps at most one entry per address and type
    assign do_merge  = store_en_i & (|exact_match);
    assign do_append = store_en_i & ~(|exact_match) & ~full;
    assign do_pop    = flush_en_i & ~empty;

    // Forwarding only when a single entry covers the word and matches exactly
    assign load_hit = $onehot(word_match) & (|exact_match);

    always_comb begin
        status_o = '0;
        if (store_en_i) begin
            status_o.hit     = do_merge;
            status_o.merge   = do_merge;
            status_o.miss    = do_append;
            status_o.trouble = ~(|exact_match) & full;
        end else if (load_en_i) begin
            status_o.hit     = load_hit;
            status_o.miss    = ~(|word_match);
            status_o.trouble = (|word_match) & ~load_hit;
        end
        status_o.data_valid = ~empty;
        status_o.data_load  = entry_q[match_idx].data;
        status_o.head_data  = entry_q[head_q].data;
        status_o.head_addr  = entry_q[head_q].addr;
        status_o.head_mtype = entry_q[head_q].mtype;
        status_o.head_id    = entry_q[head_q].id;
    end

    // Head and tail only meet when empty or full, so append and pop never collide
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (do_append) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= ptr_inc(tail_q);
            end
            if (do_pop) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= ptr_inc(head_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_append) begin
            entry_q[tail_q].addr  <= addr_i;
            entry_q[tail_q].data  <= data_i;
            entry_q[tail_q].mtype <= mtype_i;
            entry_q[tail_q].id    <= id_i;
        end else if (do_merge) begin
            entry_q[match_idx].data <= data_i;
            entry_q[match_idx].id   <= id_i;
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_tags.sv
`include "dmem_cfg.svh"

`default_nettype none

module dcache_tags (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  lookup_en_i,
    input  wire dmem_pkg::addr_t       addr_i,
    input  wire dmem_pkg::mmu_fill_t   fill_i,
    output dmem_pkg::tag_lookup_t      lookup_o
);

    localparam int LINES = `DMEM_LINES;

    logic [LINES-1:0]    valid_q;
    dmem_pkg::line_tag_t tag_q [LINES];

    dmem_pkg::line_tag_t req_tag;
    dmem_pkg::line_tag_t fill_tag;
    logic [LINES-1:0]    match;
    dmem_pkg::line_idx_t hit_idx;

    assign req_tag  = addr_i[`DMEM_ADDR_W-1:`DMEM_OFFSET_W];
    assign fill_tag = fill_i.addr[`DMEM_ADDR_W-1:`DMEM_OFFSET_W];

    // Fully associative compare against every valid line
    always_comb begin
        match   = '0;
        hit_idx = '0;
        for (int i = 0; i < LINES; i++) begin
            if (valid_q[i] && (tag_q[i] == req_tag)) begin
                match[i] = 1'b1;
                hit_idx  = dmem_pkg::line_idx_t'(i);
            end
        end
    end

    always_comb begin
        lookup_o.hit   = lookup_en_i & (|match);
        lookup_o.miss  = lookup_en_i & ~(|match);
        lookup_o.index = hit_idx;
        // Line about to be replaced, for write-back
        lookup_o.victim_addr = {tag_q[fill_i.lru_index], {`DMEM_OFFSET_W{1'b0}}};
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < LINES; i++) begin
                tag_q[i] <= '0;
            end
        end else if (fill_i.rdy) begin
            valid_q[fill_i.lru_index] <= 1'b1;
            tag_q[fill_i.lru_index]   <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// File: source/dmem_pkg.sv
`include "dmem_cfg.svh"

`default_nettype none

package dmem_pkg;

    typedef logic [`DMEM_ADDR_W-1:0] addr_t;
    typedef logic [`DMEM_DATA_W-1:0] word_t;
    typedef logic [`DMEM_REG_W-1:0] reg_addr_t;
    // Address bits above the line offset
    typedef logic [`DMEM_ADDR_W-`DMEM_OFFSET_W-1:0] line_tag_t;
    typedef logic [$clog2(`DMEM_LINES)-1:0] line_idx_t;
    typedef logic [`DMEM_ID_W-1:0] instr_id_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_type_e;

    typedef enum logic [1:0] {
        TL_IDLE,
        MISS_IN_FLIGHT,
        HAZARD_DC_MISS,
        HAZARD_SB_TROUBLE
    } tl_state_e;

    // Request from the execute stage
    typedef struct packed {
        addr_t       addr;
        logic        rf_we;
        reg_addr_t   rf_waddr;
        word_t       st_data;
        logic        rd;
        logic        wr;
        logic        sign_ext;
        memop_type_e mtype;
        instr_id_t   instr_id;
    } ex_req_t;

    // Stage register towards the memory stage
    typedef struct packed {
        addr_t       addr;
        logic        rf_we;
        reg_addr_t   rf_waddr;
        line_idx_t   addr_index;
        logic        rd;
        logic        wr;
        logic        sign_ext;
        memop_type_e mtype;
        memop_type_e flush_mtype;
        logic        sb_hit;
        logic        sb_flush;
        logic        sb_merge;
        word_t       sb_data_load;
        word_t       sb_data_flush;
        addr_t       sb_addr;
        instr_id_t   instr_id;
    } mem_out_t;

    // Line fill returned by memory
    typedef struct packed {
        logic      rdy;
        line_idx_t lru_index;
        addr_t     addr;
    } mmu_fill_t;

    typedef struct packed {
        logic      hit;
        logic      miss;
        line_idx_t index;
        addr_t     victim_addr;
    } tag_lookup_t;

    typedef struct packed {
        logic        hit;
        logic        miss;
        logic        trouble;
        logic        merge;
        logic        data_valid;
        word_t       data_load;
        word_t       head_data;
        addr_t       head_addr;
        memop_type_e head_mtype;
        instr_id_t   head_id;
    } sb_status_t;

endpackage

`default_nettype wire

// File: source/dmem_cfg.svh
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

`default_nettype none

// Address, data and register file widths
`define DMEM_ADDR_W 32
`define DMEM_DATA_W 32
`define DMEM_REG_W 5

// Data cache geometry, 16-byte lines
`define DMEM_OFFSET_W 4
`define DMEM_LINES 4

// Store buffer depth
`define DMEM_SB_ENTRIES 2

// Instruction id carried along the pipeline
`define DMEM_ID_W 3

`default_nettype wire

`endif
